//--- hw_overlay_pkg.sv
package hw_overlay_pkg;

    // Pixel and coordinate widths.
    localparam int COLOR_W = 10;
    localparam int COORD_W = 11;

    typedef struct packed {
        logic [COLOR_W-1:0] red;
        logic [COLOR_W-1:0] green;
        logic [COLOR_W-1:0] blue;
    } pixel_color_t;

    // Handwriting bitmap geometry.
    localparam int CELL_COLS  = 30;
    localparam int CELL_ROWS  = 30;
    localparam int CELL_COUNT = CELL_COLS * CELL_ROWS;
    localparam int CELL_PX    = 3;
    localparam int FRAME_PX   = 5;
    localparam int PAD_PX     = 2 * FRAME_PX + CELL_COLS * CELL_PX;

    typedef logic [$clog2(CELL_COUNT)-1:0] cell_idx_t;

    localparam logic [COLOR_W-1:0] CH_ON  = '1;
    localparam logic [COLOR_W-1:0] CH_OFF = '0;

    localparam pixel_color_t WHITE = '{CH_ON, CH_ON, CH_ON};

    // Classic bar order, left to right.
    localparam pixel_color_t BAR_COLORS [0:7] = '{
        '{CH_ON,  CH_ON,  CH_ON},
        '{CH_ON,  CH_ON,  CH_OFF},
        '{CH_OFF, CH_ON,  CH_ON},
        '{CH_OFF, CH_ON,  CH_OFF},
        '{CH_ON,  CH_OFF, CH_ON},
        '{CH_ON,  CH_OFF, CH_OFF},
        '{CH_OFF, CH_OFF, CH_ON},
        '{CH_OFF, CH_OFF, CH_OFF}
    };

endpackage

//--- pixel_if.sv
`timescale 1ns/1ps

interface pixel_if;
    import hw_overlay_pkg::*;

    // One pixel per clock, no handshake.
    logic [COORD_W-1:0] x;
    logic [COORD_W-1:0] y;
    logic               active;
    pixel_color_t       color;

    modport src (
        output x,
        output y,
        output active,
        output color
    );

    modport snk (
        input x,
        input y,
        input active,
        input color
    );

endinterface

//--- video_timing.sv
`timescale 1ns/1ps

module video_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_TOTAL  = 800,
    parameter int V_ACTIVE = 480,
    parameter int V_TOTAL  = 525
) (
    input  logic   i_clk,
    input  logic   i_rst_n,
    pixel_if.src   o_px
);
    import hw_overlay_pkg::*;

    logic [COORD_W-1:0] h_cnt;
    logic [COORD_W-1:0] v_cnt;
    logic               h_wrap;
    logic               v_wrap;

    assign h_wrap = (h_cnt == COORD_W'(H_TOTAL - 1));
    assign v_wrap = (v_cnt == COORD_W'(V_TOTAL - 1));

    // Horizontal counter runs every clock.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            h_cnt <= '0;
        end else if (h_wrap) begin
            h_cnt <= '0;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Vertical counter steps at the end of each line.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            v_cnt <= '0;
        end else if (h_wrap) begin
            if (v_wrap) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end
    end

    assign o_px.x      = h_cnt;
    assign o_px.y      = v_cnt;
    assign o_px.active = (h_cnt < COORD_W'(H_ACTIVE)) && (v_cnt < COORD_W'(V_ACTIVE));

endmodule

//--- color_bar_gen.sv
`timescale 1ns/1ps

module color_bar_gen (
    pixel_if.snk i_px,
    pixel_if.src o_px
);
    import hw_overlay_pkg::*;

    localparam int BAR_PX = 80;
    localparam int BARS   = 8;

    logic [2:0] bar;

    // Divide the column by the bar width with a ladder of compares.
    always_comb begin
        bar = 3'(BARS - 1);
        for (int i = BARS - 2; i >= 0; i--) begin
            if (i_px.x < COORD_W'((i + 1) * BAR_PX)) begin
                bar = 3'(i);
            end
        end
    end

    assign o_px.x      = i_px.x;
    assign o_px.y      = i_px.y;
    assign o_px.active = i_px.active;

    // Blanking stays black.
    assign o_px.color  = i_px.active ? BAR_COLORS[bar] : '0;

endmodule

//--- handwrite_canvas.sv
`timescale 1ns/1ps

module handwrite_canvas (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic                                i_pen_we,
    input  logic                                i_pen_clr,
    input  logic                                i_pen_val,
    input  logic [4:0]                          i_pen_col,
    input  logic [4:0]                          i_pen_row,
    output logic [hw_overlay_pkg::CELL_COUNT-1:0] o_bitmap
);
    import hw_overlay_pkg::*;

    logic [CELL_COUNT-1:0] cells;
    cell_idx_t             wr_idx;
    logic                  wr_ok;

    // Pen positions off the grid are dropped.
    assign wr_ok = (i_pen_col < 5'(CELL_COLS)) && (i_pen_row < 5'(CELL_ROWS));

    // Row-major cell index.
    assign wr_idx = cell_idx_t'(i_pen_row) * cell_idx_t'(CELL_COLS)
                  + cell_idx_t'(i_pen_col);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cells <= '0;
        end else if (i_pen_clr) begin
            // Clear wins over a write in the same cycle.
            cells <= '0;
        end else if (i_pen_we && wr_ok) begin
            cells[wr_idx] <= i_pen_val;
        end
    end

    assign o_bitmap = cells;

endmodule

//--- add_hand_write.sv
`timescale 1ns/1ps

module add_hand_write #(
    parameter int PAD_X   = 536,
    parameter int PAD_Y   = 180,
    parameter int SLIDE_Y = 330
) (
    input  logic                                 i_clk,
    input  logic                                 i_rst_n,
    pixel_if.snk                                 i_px,
    input  logic [hw_overlay_pkg::CELL_COUNT-1:0] i_bitmap,
    input  logic [hw_overlay_pkg::COORD_W-1:0]    i_displacement,
    output logic [hw_overlay_pkg::COORD_W-1:0]    o_x,
    output logic [hw_overlay_pkg::COORD_W-1:0]    o_y,
    output logic                                 o_active,
    output logic [hw_overlay_pkg::COLOR_W-1:0]    o_red,
    output logic [hw_overlay_pkg::COLOR_W-1:0]    o_green,
    output logic [hw_overlay_pkg::COLOR_W-1:0]    o_blue
);
    import hw_overlay_pkg::*;

    // Signed offsets need room for negative values and the displacement.
    localparam int OFF_W = COORD_W + 2;
    localparam int RECIP = (65536 + CELL_PX - 1) / CELL_PX;

    logic signed [OFF_W-1:0] dx;
    logic signed [OFF_W-1:0] dy_fix;
    logic signed [OFF_W-1:0] dy_slide;
    logic                    in_fix_box;
    logic                    in_slide_box;
    logic                    fix_frame;
    logic                    slide_frame;
    logic [6:0]              col_off;
    logic [6:0]              row_off;
    cell_idx_t               cell_idx;
    pixel_color_t            color_next;

    logic [COORD_W-1:0]      px_x;
    logic [COORD_W-1:0]      px_y;
    logic                    px_active;
    pixel_color_t            px_color;

    function automatic logic in_span(input logic signed [OFF_W-1:0] d);
        return (d >= 0) && (d < PAD_PX);
    endfunction

    function automatic logic on_frame(input logic signed [OFF_W-1:0] d);
        return (d < FRAME_PX) || (d >= PAD_PX - FRAME_PX);
    endfunction

    // Divide by the cell size via a 16-bit reciprocal.
    function automatic logic [4:0] to_cell(input logic [6:0] off);
        logic [22:0] prod;
        prod = 23'(off) * 23'(RECIP);
        return prod[20:16];
    endfunction

    assign dx       = OFF_W'($signed({2'b00, i_px.x}) - PAD_X);
    assign dy_fix   = OFF_W'($signed({2'b00, i_px.y}) - PAD_Y);
    // Sliding box top is SLIDE_Y minus the displacement.
    assign dy_slide = OFF_W'($signed({2'b00, i_px.y}) - SLIDE_Y
                    + $signed({2'b00, i_displacement}));

    assign in_fix_box   = (i_displacement == '0) && in_span(dx) && in_span(dy_fix);
    assign in_slide_box = (i_displacement != '0) && in_span(dx) && in_span(dy_slide);
    assign fix_frame    = on_frame(dx) || on_frame(dy_fix);
    assign slide_frame  = on_frame(dx) || on_frame(dy_slide);

    assign col_off  = 7'(dx - FRAME_PX);
    assign row_off  = 7'(dy_fix - FRAME_PX);
    assign cell_idx = cell_idx_t'(to_cell(row_off)) * cell_idx_t'(CELL_COLS)
                    + cell_idx_t'(to_cell(col_off));

    always_comb begin
        color_next = i_px.color;
        if (!i_px.active) begin
            color_next = '0;
        end else if (in_fix_box) begin
            if (fix_frame) begin
                color_next = WHITE;
            end else if (i_bitmap[cell_idx]) begin
                color_next = WHITE;
            end
        end else if (in_slide_box && slide_frame) begin
            // Pad still sliding in, frame only.
            color_next = WHITE;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            px_x      <= '0;
            px_y      <= '0;
            px_active <= 1'b0;
            px_color  <= '0;
        end else begin
            px_x      <= i_px.x;
            px_y      <= i_px.y;
            px_active <= i_px.active;
            px_color  <= color_next;
        end
    end

    assign o_x      = px_x;
    assign o_y      = px_y;
    assign o_active = px_active;
    assign o_red    = px_color.red;
    assign o_green  = px_color.green;
    assign o_blue   = px_color.blue;

endmodule

//--- hw_display_top.sv
`timescale 1ns/1ps

module hw_display_top #(
    parameter int H_ACTIVE = 640,
    parameter int H_TOTAL  = 800,
    parameter int V_ACTIVE = 480,
    parameter int V_TOTAL  = 525,
    parameter int PAD_X    = 536,
    parameter int PAD_Y    = 180,
    parameter int SLIDE_Y  = 330
) (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic [hw_overlay_pkg::COORD_W-1:0] i_displacement,
    input  logic                              i_pen_we,
    input  logic                              i_pen_clr,
    input  logic                              i_pen_val,
    input  logic [4:0]                        i_pen_col,
    input  logic [4:0]                        i_pen_row,
    output logic [hw_overlay_pkg::COORD_W-1:0] o_x,
    output logic [hw_overlay_pkg::COORD_W-1:0] o_y,
    output logic                              o_active,
    output logic [hw_overlay_pkg::COLOR_W-1:0] o_red,
    output logic [hw_overlay_pkg::COLOR_W-1:0] o_green,
    output logic [hw_overlay_pkg::COLOR_W-1:0] o_blue
);
    import hw_overlay_pkg::*;

    logic [CELL_COUNT-1:0] bitmap;

    pixel_if raw_px ();
    pixel_if bg_px ();

    video_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_TOTAL  (V_TOTAL)
    ) u_timing (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .o_px    (raw_px)
    );

    color_bar_gen u_bars (
        .i_px (raw_px),
        .o_px (bg_px)
    );

    handwrite_canvas u_canvas (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_pen_we  (i_pen_we),
        .i_pen_clr (i_pen_clr),
        .i_pen_val (i_pen_val),
        .i_pen_col (i_pen_col),
        .i_pen_row (i_pen_row),
        .o_bitmap  (bitmap)
    );

    add_hand_write #(
        .PAD_X   (PAD_X),
        .PAD_Y   (PAD_Y),
        .SLIDE_Y (SLIDE_Y)
    ) u_overlay (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_px           (bg_px),
        .i_bitmap       (bitmap),
        .i_displacement (i_displacement),
        .o_x            (o_x),
        .o_y            (o_y),
        .o_active       (o_active),
        .o_red          (o_red),
        .o_green        (o_green),
        .o_blue         (o_blue)
    );

endmodule

//--- tb_hw_display.sv
`timescale 1ns/1ps

module tb_hw_display;

    localparam int CLK_HALF = 4;
    localparam int SEED     = 37;
    localparam int H_TOTAL  = 800;
    localparam int V_TOTAL  = 525;
    localparam int WAIT_MAX = 500000;

    logic        i_clk;
    logic        i_rst_n;
    logic [10:0] i_displacement;
    logic        i_pen_we;
    logic        i_pen_clr;
    logic        i_pen_val;
    logic [4:0]  i_pen_col;
    logic [4:0]  i_pen_row;
    logic [10:0] o_x;
    logic [10:0] o_y;
    logic        o_active;
    logic [9:0]  o_red;
    logic [9:0]  o_green;
    logic [9:0]  o_blue;

    // Reference state of the pad.
    logic        model_cells [0:29][0:29];
    int          model_disp;

    logic [31:0] rng;
    int          errors;
    bit          timed_out;
    bit          mon_en;
    int          prev_x;
    int          prev_y;
    int          exp_x;
    int          exp_y;
    logic [29:0] exp_rgb;

    hw_display_top UUT (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_displacement (i_displacement),
        .i_pen_we       (i_pen_we),
        .i_pen_clr      (i_pen_clr),
        .i_pen_val      (i_pen_val),
        .i_pen_col      (i_pen_col),
        .i_pen_row      (i_pen_row),
        .o_x            (o_x),
        .o_y            (o_y),
        .o_active       (o_active),
        .o_red          (o_red),
        .o_green        (o_green),
        .o_blue         (o_blue)
    );

    always #CLK_HALF i_clk = ~i_clk;

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    // Eight bars of 80 columns with each channel fully on or off.
    function automatic logic [29:0] bar_color(input int x);
        logic [2:0] rgb;
        case (x / 80)
            0:       rgb = 3'b111;
            1:       rgb = 3'b110;
            2:       rgb = 3'b011;
            3:       rgb = 3'b010;
            4:       rgb = 3'b101;
            5:       rgb = 3'b100;
            6:       rgb = 3'b001;
            default: rgb = 3'b000;
        endcase
        return {{10{rgb[2]}}, {10{rgb[1]}}, {10{rgb[0]}}};
    endfunction

    function automatic logic [29:0] expected_color(input int x, input int y);
        int cx;
        int cy;
        int top;
        cx = x - 536;
        if (x >= 640 || y >= 480) begin
            return '0;
        end
        if (model_disp == 0) begin
            cy = y - 180;
            if (cx >= 0 && cx < 100 && cy >= 0 && cy < 100) begin
                if (cx < 5 || cx > 94 || cy < 5 || cy > 94) begin
                    return '1;
                end
                if (model_cells[(cy - 5) / 3][(cx - 5) / 3]) begin
                    return '1;
                end
            end
        end else begin
            top = 330 - model_disp;
            cy = y - top;
            if (cx >= 0 && cx < 100 && cy >= 0 && cy < 100 &&
                (cx < 5 || cx > 94 || cy < 5 || cy > 94)) begin
                return '1;
            end
        end
        return bar_color(x);
    endfunction

    // Check raster stepping and pixel color on the falling edge.
    always @(negedge i_clk) begin
        if (mon_en) begin
            exp_x = (prev_x == H_TOTAL - 1) ? 0 : prev_x + 1;
            exp_y = prev_y;
            if (prev_x == H_TOTAL - 1) begin
                exp_y = (prev_y == V_TOTAL - 1) ? 0 : prev_y + 1;
            end
            check_value("o_x", 32'(exp_x), 32'(o_x));
            check_value("o_y", 32'(exp_y), 32'(o_y));
            exp_rgb = expected_color(int'(o_x), int'(o_y));
            check_value("o_active", 32'(o_x < 11'd640 && o_y < 11'd480), 32'(o_active));
            check_value("o_red", 32'(exp_rgb[29:20]), 32'(o_red));
            check_value("o_green", 32'(exp_rgb[19:10]), 32'(o_green));
            check_value("o_blue", 32'(exp_rgb[9:0]), 32'(o_blue));
            prev_x = int'(o_x);
            prev_y = int'(o_y);
        end
    end

    task automatic wait_for_line(input int line);
        int count;
        count = 0;
        while (!timed_out && !(int'(o_y) == line && o_x == 11'd0)) begin
            @(negedge i_clk);
            count++;
            if (count > WAIT_MAX) begin
                timed_out = 1'b1;
                errors++;
                $display("Timeout while waiting for the start of line %0d", line);
            end
        end
    endtask

    // Issue one pen strobe and mirror it into the model at the same edge.
    task automatic pen_write(input logic clr);
        logic [31:0] r;
        logic        val;
        r   = next_rand();
        val = (r[11:10] != 2'b00);
        @(posedge i_clk);
        i_pen_col <= r[4:0];
        i_pen_row <= r[9:5];
        i_pen_val <= val;
        i_pen_we  <= 1'b1;
        i_pen_clr <= clr;
        if (clr) begin
            for (int i = 0; i < 30; i++) begin
                for (int j = 0; j < 30; j++) begin
                    model_cells[i][j] = 1'b0;
                end
            end
        end else if (r[4:0] < 5'd30 && r[9:5] < 5'd30) begin
            model_cells[r[9:5]][r[4:0]] = val;
        end
        @(posedge i_clk);
        i_pen_we  <= 1'b0;
        i_pen_clr <= 1'b0;
    endtask

    task automatic blank_actions(input int step);
        logic [31:0] r;
        if (step == 2) begin
            pen_write(1'b1);
        end else begin
            for (int n = 0; n < 60; n++) begin
                pen_write(1'b0);
            end
        end
        r = next_rand();
        @(posedge i_clk);
        model_disp = (step % 2 == 1) ? int'(r % 400) + 1 : 0;
        i_displacement <= 11'(model_disp);
    endtask

    initial begin
        rng            = SEED;
        errors         = 0;
        timed_out      = 1'b0;
        mon_en         = 1'b0;
        // The first pixel after reset must be the raster origin.
        prev_x         = H_TOTAL - 1;
        prev_y         = V_TOTAL - 1;
        model_disp     = 0;
        i_clk          = 1'b0;
        i_rst_n        = 1'b0;
        i_displacement = '0;
        i_pen_we       = 1'b0;
        i_pen_clr      = 1'b0;
        i_pen_val      = 1'b0;
        i_pen_col      = '0;
        i_pen_row      = '0;
        for (int i = 0; i < 30; i++) begin
            for (int j = 0; j < 30; j++) begin
                model_cells[i][j] = 1'b0;
            end
        end
        repeat (2) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(negedge i_clk);
        check_value("o_x", 32'd0, 32'(o_x));
        check_value("o_y", 32'd0, 32'(o_y));
        check_value("o_active", 32'd0, 32'(o_active));
        check_value("o_red", 32'd0, 32'(o_red));
        check_value("o_green", 32'd0, 32'(o_green));
        check_value("o_blue", 32'd0, 32'(o_blue));
        @(posedge i_clk);
        mon_en <= 1'b1;
        // Pen and displacement changes only in vertical blanking.
        for (int b = 0; b < 4; b++) begin
            wait_for_line(490);
            if (!timed_out) begin
                blank_actions(b);
            end
        end
        wait_for_line(0);
        wait_for_line(490);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- project.f
hw_overlay_pkg.sv
pixel_if.sv
video_timing.sv
color_bar_gen.sv
handwrite_canvas.sv
add_hand_write.sv
hw_display_top.sv
tb_hw_display.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f project.f --top-module tb_hw_display -o tb_hw_display \
    > sim.log 2>&1 \
    && ./obj_dir/tb_hw_display >> sim.log 2>&1 \
    || echo "sim failed" >> sim.log
cat sim.log
if grep -q "sim failed" sim.log; then
    exit 1
fi
grep -q "sim passed" sim.log || exit 1
exit 0
